//--- Bender.yml
package:
  name: csr_top

sources:
  - files:
      - verilog/csr_pkg.sv
      - verilog/csr_read_decode.sv
      - verilog/csr_trap_regs.sv
      - verilog/csr_counters.sv
      - verilog/csr_trap_request.sv
      - verilog/csr_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/csr_properties.sv
      - testbench/tb_csr_top.sv

//--- filelist.f
verilog/csr_pkg.sv
verilog/csr_read_decode.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_trap_request.sv
verilog/csr_top.sv
testbench/tb_clock_gen.sv
testbench/csr_properties.sv
testbench/tb_csr_top.sv

//--- testbench/csr_properties.sv
// Concurrent assertions on the CSR register port and trap handshake, bound to csr_top
`default_nettype none

module csr_properties import csr_pkg::*; (
	input wire          clk,
	input wire          rst_n,
	input wire          wen,
	input wire          ren,
	input wire          illegal,
	input wire word_t   trap_addr,
	input wire          trap_enter_vld,
	input wire          trap_enter_rdy,
	input wire except_t except
);

	// No access, no illegal flag
	a_idle_legal: assert property (@(posedge clk) disable iff (!rst_n)
		(!wen && !ren) |-> !illegal)
		else $error("illegal raised without an access");

	// Vector targets are word aligned
	a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(trap_enter_vld && except != EXCEPT_MRET) |-> trap_addr[1:0] == 2'b00)
		else $error("trap target not word aligned");

	// Request held while stalled and cause unchanged
	a_vld_held: assert property (@(posedge clk) disable iff (!rst_n)
		(trap_enter_vld && !trap_enter_rdy && except != EXCEPT_NONE)
		##1 (except == $past(except)) |-> trap_enter_vld)
		else $error("trap request dropped under back-pressure");

endmodule

bind csr_top csr_properties u_props (
	.clk, .rst_n, .wen, .ren, .illegal, .trap_addr, .trap_enter_vld,
	.trap_enter_rdy, .except
);

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock and power-on reset generator
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;  // Held low from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk) rst_n = 1'b1;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/tb_csr_top.sv
// CSR block testbench: stimulus, shadow register model, comparison process and report
`default_nettype none

module tb_csr_top import csr_pkg::*;;

	logic clk, rst_n;
	logic [11:0] addr;
	logic [31:0] wdata, rdata, trap_addr, mepc_in;
	logic [1:0] wtype;
	logic wen, ren, illegal, trap_is_irq, trap_enter_vld, trap_enter_rdy;
	logic delay_irq_entry, instr_ret;
	logic [15:0] irq;
	logic [3:0] except;

	// Shadow state of the register model
	logic [31:0] sh_mscratch, sh_mtvec, sh_mepc, sh_mie, sh_mcause;
	logic sh_mstatus_mie, sh_mstatus_mpie;
	logic [15:0] sh_irq;

	logic [31:0] exp_rdata;
	logic exp_illegal, compare_en, exp_rd;
	int err_count = 0;
	int check_count = 0;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) u_clk (.clk, .rst_n);

	csr_top UUT (
		.clk, .rst_n, .addr, .wdata, .wtype(csr_wtype_t'(wtype)), .wen, .ren, .rdata,
		.illegal, .trap_addr, .trap_is_irq, .trap_enter_vld, .trap_enter_rdy, .mepc_in,
		.delay_irq_entry, .irq, .except, .instr_ret
	);

	// ------------------------------------------------------------------------
	// Reference model
	function automatic logic [31:0] model_apply(input logic [31:0] p, input logic [31:0] v,
		input logic [1:0] t);
		return (t == 2'd1) ? (p | v) : (t == 2'd2) ? (p & ~v) : v;
	endfunction

	function automatic logic [31:0] mstatus_value();
		return {19'd0, 2'b11, 3'd0, sh_mstatus_mpie, 3'd0, sh_mstatus_mie, 3'd0};
	endfunction

	function automatic logic [31:0] ref_rdata(input logic [11:0] a);
		case (a)
			12'h300: return mstatus_value();
			12'h301: return 32'h4000_1104;                // RV32 I, M, C
			12'h304: return sh_mie;
			12'h305: return {sh_mtvec[31:2], 2'b01};      // Vectored
			12'h340: return sh_mscratch;
			12'h341: return sh_mepc;
			12'h342: return sh_mcause;
			12'h344: return {sh_irq, 4'h0, |sh_irq, 11'd0};
			default: return 32'h0;  // mtval, mcountinhibit, ID regs, unmapped
		endcase
	endfunction

	function automatic logic ref_illegal(input logic [11:0] a, input logic w, input logic r);
		logic mapped;
		mapped = a inside {12'h300, 12'h301, 12'h304, 12'h305, 12'h320, [12'h340:12'h344],
			[12'hb00:12'hb02], [12'hb80:12'hb82], [12'hf11:12'hf14]};
		return (w || r) && (!mapped || (w && a inside {[12'hf11:12'hf14]}));
	endfunction

	function automatic logic [31:0] vector_target(input logic [4:0] code);
		return {sh_mtvec[31:2], 2'b00} + {25'd0, code, 2'b00};
	endfunction

	function automatic int lowest_bit(input logic [15:0] v);
		for (int k = 0; k < 16; k++)
			if (v[k])
				return k;
		return 0;
	endfunction

	task automatic model_write(input logic [11:0] a, input logic [31:0] d, input logic [1:0] t);
		logic [31:0] tmp;
		case (a)
			12'h300: begin
				tmp = model_apply(mstatus_value(), d, t);
				sh_mstatus_mpie = tmp[7];
				sh_mstatus_mie  = tmp[3];
			end
			12'h304: sh_mie      = model_apply(sh_mie, d, t) & 32'hffff_0888;
			12'h305: sh_mtvec    = model_apply(sh_mtvec, d, t) & 32'hffff_fffc;
			12'h340: sh_mscratch = model_apply(sh_mscratch, d, t);
			12'h341: sh_mepc     = model_apply(sh_mepc, d, t) & 32'hffff_fffe;
			12'h342: sh_mcause   = model_apply(sh_mcause, d, t) & 32'h8000_001f;
			default: ;  // Read-only or counter
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Checks and drivers
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Compared just before the edge, inputs settled since the falling edge
	always @(posedge clk) begin
		if (compare_en) begin
			if (exp_rd)
				check("rdata", rdata, exp_rdata);
			check("illegal", illegal, exp_illegal);
		end
	end

	// One register port cycle, model follows after the edge
	task automatic access(input logic [11:0] a, input logic w, input logic r,
		input logic [31:0] d, input logic [1:0] t);
		addr = a;
		wen = w;
		ren = r;
		wdata = d;
		wtype = t;
		exp_rdata = ref_rdata(a);
		exp_illegal = ref_illegal(a, w, r);
		exp_rd = r;
		compare_en = 1'b1;
		@(negedge clk);
		wen = 1'b0;
		ren = 1'b0;
		compare_en = 1'b0;
		if (w)
			model_write(a, d, t);
	endtask

	task automatic read_counter(input logic [11:0] a, output logic [31:0] v);
		addr = a;
		ren = 1'b1;
		@(posedge clk) v = rdata;
		@(negedge clk) ren = 1'b0;
	endtask

	task automatic expect_trap(input logic vld, input logic is_irq, input logic [31:0] target);
		@(posedge clk);
		check("trap_enter_vld", trap_enter_vld, vld);
		check("trap_is_irq", trap_is_irq, is_irq);
		if (vld)
			check("trap_addr", trap_addr, target);
		@(negedge clk);
	endtask

	task automatic accept_trap();
		logic done;
		done = 1'b0;
		trap_enter_rdy = 1'b1;
		for (int n = 0; n < 10 && !done; n++)
			@(posedge clk) done = trap_enter_vld;
		if (!done) begin
			$display("timeout: trap request was never accepted");
			$display("Verification failed");
			$finish;
		end
		@(negedge clk);
		trap_enter_rdy = 1'b0;
		except = EXCEPT_NONE;
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	initial begin
		logic [11:0] regs [5];
		logic [31:0] c0, c1, x, v, m;
		logic [3:0] code;
		int n, k, pulses;
		logic rst_seen;

		regs = '{12'h340, 12'h304, 12'h305, 12'h341, 12'h342};
		x = $urandom(32'h5c51);
		{addr, wdata, wtype, wen, ren, mepc_in, instr_ret, irq} = '0;
		{trap_enter_rdy, delay_irq_entry, compare_en, exp_rd} = '0;
		except = EXCEPT_NONE;
		{sh_mscratch, sh_mtvec, sh_mepc, sh_mie, sh_mcause, sh_irq} = '0;
		{sh_mstatus_mie, sh_mstatus_mpie} = '0;
		rst_seen = 1'b0;
		for (n = 0; n < 20 && !rst_seen; n++)
			@(posedge clk) rst_seen = rst_n;  // Reset lifts on a falling edge
		if (!rst_seen) begin
			$display("timeout: reset never released");
			$display("Verification failed");
			$finish;
		end
		@(negedge clk);
		expect_trap(1'b0, 1'b1, 32'h0);

		// Random write, set and clear with read-back
		for (n = 0; n < 40; n++) begin
			k = $urandom_range(0, 4);
			access(regs[k], 1'b1, 1'b0, $urandom, 2'($urandom_range(0, 2)));
			access(regs[k], 1'b0, 1'b1, 32'h0, 2'd0);
		end

		// Illegal and fixed registers
		access(12'h3a0, 1'b1, 1'b0, $urandom, 2'd1);
		access(12'h123, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h7c0, 1'b1, 1'b0, $urandom, 2'd0);
		access(12'hfff, 1'b1, 1'b1, $urandom, 2'd0);
		for (n = 12'hf11; n <= 12'hf14; n++) begin
			access(12'(n), 1'b0, 1'b1, 32'h0, 2'd0);
			access(12'(n), 1'b1, 1'b0, $urandom, 2'd0);
		end
		foreach (regs[i]) begin
			access(12'h301, 1'b1, 1'b0, $urandom, 2'd0);  // misa ignores writes
			access(12'h344, 1'b1, 1'b0, $urandom, 2'd1);
			access(12'h343, 1'b1, 1'b0, $urandom, 2'd0);
			access(12'h320, 1'b1, 1'b0, $urandom, 2'd0);
		end
		access(12'h301, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h300, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h344, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h343, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h320, 1'b0, 1'b1, 32'h0, 2'd0);
		foreach (regs[i])
			access(regs[i], 1'b0, 1'b1, 32'h0, 2'd0);

		// ---------------------------------------------------------------------
		// Counters
		read_counter(12'hb00, c0);
		n = $urandom_range(3, 20);
		repeat (n) @(negedge clk);
		read_counter(12'hb00, c1);
		check("mcycle delta", c1 - c0, n + 1);  // One more edge per read
		read_counter(12'hb01, c0);
		check("mtime", c0, c1 + 1);
		x = $urandom & 32'h0fff_ffff;
		access(12'hb00, 1'b1, 1'b0, x, 2'd0);
		read_counter(12'hb00, c0);
		check("mcycle written", c0, x);
		repeat (5) @(negedge clk);
		read_counter(12'hb00, c0);
		check("mcycle continued", c0, x + 6);
		x = $urandom;
		access(12'hb80, 1'b1, 1'b0, x, 2'd0);
		repeat (4) @(negedge clk);
		read_counter(12'hb80, c0);
		check("mcycleh", c0, x);
		access(12'hb02, 1'b1, 1'b0, 32'h0, 2'd0);
		pulses = 0;
		repeat ($urandom_range(10, 30)) begin
			instr_ret = 1'($urandom);
			pulses += instr_ret;
			@(negedge clk);
		end
		instr_ret = 1'b0;
		read_counter(12'hb02, c0);
		check("minstret", c0, pulses);
		read_counter(12'hb82, c0);
		check("minstreth", c0, 32'h0);

		// ---------------------------------------------------------------------
		// Exception with back-pressure
		access(12'h300, 1'b1, 1'b0, 32'h8, 2'd0);  // MIE on
		code = 4'($urandom_range(0, 8));
		except = code;
		mepc_in = $urandom;
		repeat ($urandom_range(1, 8))
			expect_trap(1'b1, 1'b0, vector_target({1'b0, code}));
		accept_trap();
		sh_mstatus_mpie = sh_mstatus_mie;
		sh_mstatus_mie = 1'b0;
		sh_mepc = mepc_in & 32'hffff_fffe;
		sh_mcause = {28'd0, code};
		access(12'h341, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h342, 1'b0, 1'b1, 32'h0, 2'd0);
		access(12'h300, 1'b0, 1'b1, 32'h0, 2'd0);

		// ---------------------------------------------------------------------
		// Interrupts
		do begin
			v = $urandom;
			m = $urandom;
		end while ((v[15:0] & m[15:0]) == 16'h0);
		access(12'h304, 1'b1, 1'b0, {m[15:0], 16'h0800}, 2'd0);
		access(12'h300, 1'b1, 1'b0, 32'h8, 2'd0);
		irq = v[15:0];
		sh_irq = irq;
		mepc_in = $urandom;
		expect_trap(1'b0, 1'b1, 32'h0);  // Registered IRQ inputs, not seen yet
		k = lowest_bit(v[15:0] & m[15:0]);
		expect_trap(1'b1, 1'b1, vector_target(5'(16 + k)));
		access(12'h344, 1'b0, 1'b1, 32'h0, 2'd0);
		accept_trap();
		sh_mstatus_mpie = sh_mstatus_mie;
		sh_mstatus_mie = 1'b0;
		sh_mepc = mepc_in & 32'hffff_fffe;
		sh_mcause = 32'h8000_0000 | (16 + k);
		access(12'h342, 1'b0, 1'b1, 32'h0, 2'd0);
		expect_trap(1'b0, 1'b1, 32'h0);  // Global enable now off
		access(12'h300, 1'b1, 1'b0, 32'h8, 2'd1);
		expect_trap(1'b1, 1'b1, vector_target(5'(16 + k)));
		delay_irq_entry = 1'b1;
		expect_trap(1'b0, 1'b1, 32'h0);
		delay_irq_entry = 1'b0;
		access(12'h304, 1'b1, 1'b0, 32'h800, 2'd2);  // meie off
		expect_trap(1'b0, 1'b1, 32'h0);
		access(12'h304, 1'b1, 1'b0, 32'h800, 2'd1);
		access(12'h304, 1'b1, 1'b0, {v[15:0], 16'h0}, 2'd2);  // Mask the raised lines
		expect_trap(1'b0, 1'b1, 32'h0);
		access(12'h304, 1'b1, 1'b0, {m[15:0], 16'h0}, 2'd1);
		except = EXCEPT_ECALL;  // Exception beats the pending IRQ
		expect_trap(1'b1, 1'b0, vector_target(5'd8));
		except = EXCEPT_NONE;
		irq = '0;
		sh_irq = '0;
		@(negedge clk);

		// ---------------------------------------------------------------------
		// Trap return
		access(12'h341, 1'b1, 1'b0, $urandom, 2'd0);
		x = {24'd0, 1'($urandom), 7'd0};  // Random MPIE, MIE off
		access(12'h300, 1'b1, 1'b0, x, 2'd0);
		except = EXCEPT_MRET;
		expect_trap(1'b1, 1'b0, sh_mepc);
		accept_trap();
		sh_mstatus_mie = sh_mstatus_mpie;
		sh_mstatus_mpie = 1'b1;
		access(12'h300, 1'b0, 1'b1, 32'h0, 2'd0);

		repeat (2) @(negedge clk);
		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/csr_counters.sv
// Cycle and retired-instruction counters with a partial-width increment
`default_nettype none

module csr_counters import csr_pkg::*; #(
	parameter int W_COUNTER = 64  // Bits that count in hardware, upper bits only by write
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire word_t       wdata,
	input  wire csr_wtype_t  wtype,
	input  wire wsel_t       wsel,
	input  wire              instr_ret,
	output word_t            mcycle,
	output word_t            mcycleh,
	output word_t            minstret,
	output word_t            minstreth
);

	// Carry never leaves the low W_COUNTER bits
	localparam logic [63:0] INC_MASK = (W_COUNTER >= 64) ? {64{1'b1}} :
		((64'd1 << W_COUNTER) - 64'd1);

	logic [63:0] cnt [2];  // 0 is mcycle, 1 is minstret
	logic [1:0]  cnt_en;

	assign cnt_en = {instr_ret, 1'b1};  // mcycle runs every cycle

	for (genvar i = 0; i < 2; i++) begin : g_ctr
		logic        wr_lo;
		logic        wr_hi;
		logic [63:0] cnt_inc;

		assign wr_lo   = wsel[WSEL_MCYCLE + 2*i];
		assign wr_hi   = wsel[WSEL_MCYCLE + 2*i + 1];
		assign cnt_inc = ((cnt[i] + 64'd1) & INC_MASK) | (cnt[i] & ~INC_MASK);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt[i] <= '0;
			end else if (wr_lo || wr_hi) begin  // Write beats increment
				if (wr_lo)
					cnt[i][31:0] <= csr_apply(cnt[i][31:0], wdata, wtype);
				if (wr_hi)
					cnt[i][63:32] <= csr_apply(cnt[i][63:32], wdata, wtype);
			end else if (cnt_en[i]) begin
				cnt[i] <= cnt_inc;
			end
		end
	end

	assign mcycle    = cnt[0][31:0];
	assign mcycleh   = cnt[0][63:32];
	assign minstret  = cnt[1][31:0];
	assign minstreth = cnt[1][63:32];

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
// CSR types, register addresses, write selects, write masks and the write/set/clear helper
`default_nettype none

package csr_pkg;

	localparam int XLEN  = 32;  // Data width
	localparam int N_IRQ = 16;  // External interrupt lines

	typedef logic [XLEN-1:0] word_t;
	typedef logic [11:0]     csr_addr_t;

	// Operation carried by a CSR instruction
	typedef enum logic [1:0] {
		CSR_WTYPE_W = 2'h0,  // Plain write
		CSR_WTYPE_S = 2'h1,  // Set bits
		CSR_WTYPE_C = 2'h2   // Clear bits
	} csr_wtype_t;

	// -------------------------------------------------------------------------
	// Exception codes
	typedef logic [3:0] except_t;

	localparam except_t EXCEPT_INSTR_MISALIGN = 4'h0;
	localparam except_t EXCEPT_INSTR_FAULT    = 4'h1;
	localparam except_t EXCEPT_INSTR_ILLEGAL  = 4'h2;
	localparam except_t EXCEPT_EBREAK         = 4'h3;
	localparam except_t EXCEPT_LOAD_ALIGN     = 4'h4;
	localparam except_t EXCEPT_LOAD_FAULT     = 4'h5;
	localparam except_t EXCEPT_STORE_ALIGN    = 4'h6;
	localparam except_t EXCEPT_STORE_FAULT    = 4'h7;
	localparam except_t EXCEPT_ECALL          = 4'h8;
	localparam except_t EXCEPT_MRET           = 4'hb;  // Not a cause, asks for trap return
	localparam except_t EXCEPT_NONE           = 4'hf;

	// -------------------------------------------------------------------------
	// Machine-mode CSR map
	localparam csr_addr_t CSR_MSTATUS       = 12'h300;
	localparam csr_addr_t CSR_MISA          = 12'h301;
	localparam csr_addr_t CSR_MIE           = 12'h304;
	localparam csr_addr_t CSR_MTVEC         = 12'h305;
	localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
	localparam csr_addr_t CSR_MEPC          = 12'h341;
	localparam csr_addr_t CSR_MCAUSE        = 12'h342;
	localparam csr_addr_t CSR_MTVAL         = 12'h343;
	localparam csr_addr_t CSR_MIP           = 12'h344;
	localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
	localparam csr_addr_t CSR_MTIME         = 12'hb01;  // Alias of mcycle
	localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
	localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t CSR_MTIMEH        = 12'hb81;  // Alias of mcycleh
	localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;
	localparam csr_addr_t CSR_MVENDORID     = 12'hf11;
	localparam csr_addr_t CSR_MARCHID       = 12'hf12;
	localparam csr_addr_t CSR_MIMPID        = 12'hf13;
	localparam csr_addr_t CSR_MHARTID       = 12'hf14;

	// Writable bits
	localparam word_t MIE_WMASK    = 32'hffff_0888;  // Per-IRQ mask, MEIE, MTIE, MSIE
	localparam word_t MEPC_WMASK   = 32'hffff_fffe;  // Bit 0 stays clear
	localparam word_t MCAUSE_WMASK = 32'h8000_001f;  // IRQ flag and 5-bit code

	localparam logic [4:0] IRQ_CAUSE_BASE = 5'd16;  // Cause code of IRQ 0

	// One-hot write select, one bit per writable register
	localparam int N_WSEL         = 10;
	localparam int WSEL_MSTATUS   = 0;
	localparam int WSEL_MSCRATCH  = 1;
	localparam int WSEL_MTVEC     = 2;
	localparam int WSEL_MEPC      = 3;
	localparam int WSEL_MIE       = 4;
	localparam int WSEL_MCAUSE    = 5;
	localparam int WSEL_MCYCLE    = 6;  // Counter selects come in low/high pairs
	localparam int WSEL_MCYCLEH   = 7;
	localparam int WSEL_MINSTRET  = 8;
	localparam int WSEL_MINSTRETH = 9;

	typedef logic [N_WSEL-1:0] wsel_t;

	// Result of a write, set or clear applied to a previous value
	function automatic word_t csr_apply(input word_t prev, input word_t wval,
		input csr_wtype_t wtype);
		case (wtype)
			CSR_WTYPE_S: return prev | wval;
			CSR_WTYPE_C: return prev & ~wval;
			default:     return wval;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- verilog/csr_read_decode.sv
// CSR address decode: read multiplexer, one-hot write selects and illegal-access flag
`default_nettype none

module csr_read_decode import csr_pkg::*; #(
	parameter bit EXTENSION_M = 1'b1,
	parameter bit EXTENSION_C = 1'b1
) (
	input  wire csr_addr_t  addr,
	input  wire             wen,
	input  wire             ren,
	input  wire             mstatus_mpie,
	input  wire             mstatus_mie,
	input  wire word_t      mscratch,
	input  wire word_t      mtvec,
	input  wire word_t      mepc,
	input  wire word_t      mie,
	input  wire word_t      mip,
	input  wire word_t      mcause,
	input  wire word_t      mcycle,
	input  wire word_t      mcycleh,
	input  wire word_t      minstret,
	input  wire word_t      minstreth,
	output word_t           rdata,
	output logic            illegal,
	output wsel_t           wsel
);

	logic decode_match;

	always_comb begin
		decode_match = 1'b1;  // Cleared for unmapped addresses below
		rdata        = '0;
		wsel         = '0;
		case (addr)
			// -----------------------------------------------------------------
			// Information and status
			CSR_MISA: begin
				rdata = {2'h1, 4'h0, 13'd0, EXTENSION_M, 3'd0, 1'b1, 5'd0, EXTENSION_C, 2'b00};
			end
			CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
				decode_match = !wen;  // Read-only, zero for a single hart
			end
			CSR_MSTATUS: begin
				// MPP fixed at M-mode
				rdata = {19'd0, 2'b11, 3'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
				wsel[WSEL_MSTATUS] = wen;
			end
			CSR_MCOUNTINHIBIT, CSR_MTVAL: begin
				rdata = '0;  // Hardwired
			end

			// -----------------------------------------------------------------
			// Trap handling
			CSR_MSCRATCH: begin
				rdata = mscratch;
				wsel[WSEL_MSCRATCH] = wen;
			end
			CSR_MTVEC: begin
				rdata = {mtvec[XLEN-1:2], 2'b01};  // Vectored mode only
				wsel[WSEL_MTVEC] = wen;
			end
			CSR_MEPC: begin
				rdata = mepc;
				wsel[WSEL_MEPC] = wen;
			end
			CSR_MIE: begin
				rdata = mie;
				wsel[WSEL_MIE] = wen;
			end
			CSR_MIP:    rdata = mip;  // Writes ignored
			CSR_MCAUSE: begin
				rdata = mcause;  // IRQ flag at 31, code at 4:0
				wsel[WSEL_MCAUSE] = wen;
			end

			// -----------------------------------------------------------------
			// Counters, mtime aliases the cycle count
			CSR_MCYCLE: begin
				rdata = mcycle;
				wsel[WSEL_MCYCLE] = wen;
			end
			CSR_MCYCLEH: begin
				rdata = mcycleh;
				wsel[WSEL_MCYCLEH] = wen;
			end
			CSR_MINSTRET: begin
				rdata = minstret;
				wsel[WSEL_MINSTRET] = wen;
			end
			CSR_MINSTRETH: begin
				rdata = minstreth;
				wsel[WSEL_MINSTRETH] = wen;
			end
			CSR_MTIME:  rdata = mcycle;
			CSR_MTIMEH: rdata = mcycleh;

			default: decode_match = 1'b0;
		endcase
	end

	assign illegal = (wen || ren) && !decode_match;

endmodule

`default_nettype wire

//--- verilog/csr_top.sv
// Machine-mode CSR block top level: decode, trap state, counters and trap request
`default_nettype none

module csr_top import csr_pkg::*; #(
	parameter int    W_COUNTER   = 64,            // Hardware-incremented counter bits
	parameter word_t MTVEC_INIT  = 32'h0000_0000,
	parameter word_t MTVEC_WMASK = 32'hffff_fffc,
	parameter bit    EXTENSION_M = 1'b1,
	parameter bit    EXTENSION_C = 1'b1
) (
	input  wire              clk,
	input  wire              rst_n,
	// Register port, read is combinational
	input  wire csr_addr_t   addr,
	input  wire word_t       wdata,
	input  wire csr_wtype_t  wtype,
	input  wire              wen,
	input  wire              ren,
	output word_t            rdata,
	output logic             illegal,
	// Trap entry handshake
	output word_t            trap_addr,
	output logic             trap_is_irq,
	output logic             trap_enter_vld,
	input  wire              trap_enter_rdy,
	input  wire word_t       mepc_in,
	input  wire              delay_irq_entry,
	input  wire [N_IRQ-1:0]  irq,
	input  wire except_t     except,
	input  wire              instr_ret
);

	wsel_t      wsel;
	logic       mstatus_mpie;
	logic       mstatus_mie;
	word_t      mscratch;
	word_t      mtvec;
	word_t      mepc;
	word_t      mie;
	word_t      mip;
	word_t      mcause;
	word_t      mcycle;
	word_t      mcycleh;
	word_t      minstret;
	word_t      minstreth;
	logic       trap_take;
	logic       trap_is_mret;
	logic       cause_irq;
	logic [4:0] cause_code;

	csr_read_decode #(.EXTENSION_M(EXTENSION_M), .EXTENSION_C(EXTENSION_C)) u_read_decode (
		.addr, .wen, .ren, .mstatus_mpie, .mstatus_mie, .mscratch, .mtvec, .mepc,
		.mie, .mip, .mcause, .mcycle, .mcycleh, .minstret, .minstreth,
		.rdata, .illegal, .wsel
	);

	csr_trap_regs #(.MTVEC_INIT(MTVEC_INIT), .MTVEC_WMASK(MTVEC_WMASK)) u_trap_regs (
		.clk, .rst_n, .wdata, .wtype, .wsel, .trap_take, .trap_is_mret, .cause_irq,
		.cause_code, .mepc_in, .mstatus_mpie, .mstatus_mie, .mscratch, .mtvec, .mepc,
		.mie, .mcause
	);

	csr_counters #(.W_COUNTER(W_COUNTER)) u_counters (
		.clk, .rst_n, .wdata, .wtype, .wsel, .instr_ret,
		.mcycle, .mcycleh, .minstret, .minstreth
	);

	csr_trap_request u_trap_request (
		.clk, .rst_n, .irq, .except, .delay_irq_entry, .trap_enter_rdy, .mstatus_mie,
		.mie, .mtvec, .mepc, .mip, .trap_addr, .trap_is_irq, .trap_enter_vld,
		.trap_take, .trap_is_mret, .cause_irq, .cause_code
	);

endmodule

`default_nettype wire

//--- verilog/csr_trap_regs.sv
// Trap state registers: mstatus interrupt stack, mscratch, mtvec, mepc, mie and mcause
`default_nettype none

module csr_trap_regs import csr_pkg::*; #(
	parameter word_t MTVEC_INIT  = 32'h0000_0000,
	parameter word_t MTVEC_WMASK = 32'hffff_fffc
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire word_t       wdata,
	input  wire csr_wtype_t  wtype,
	input  wire wsel_t       wsel,
	input  wire              trap_take,     // Trap handshake completes this cycle
	input  wire              trap_is_mret,
	input  wire              cause_irq,
	input  wire [4:0]        cause_code,
	input  wire word_t       mepc_in,
	output logic             mstatus_mpie,
	output logic             mstatus_mie,
	output word_t            mscratch,
	output word_t            mtvec,
	output word_t            mepc,
	output word_t            mie,
	output word_t            mcause
);

	word_t mstatus_view;  // Stack bits at their architectural positions
	word_t mstatus_wr;
	logic  trap_entry;    // Trap taken, other than a return

	assign mstatus_view = {24'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};
	assign mstatus_wr   = csr_apply(mstatus_view, wdata, wtype);
	assign trap_entry   = trap_take && !trap_is_mret;

	// -------------------------------------------------------------------------
	// Two-level interrupt enable stack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mpie <= 1'b0;
			mstatus_mie  <= 1'b0;
		end else if (trap_take && trap_is_mret) begin
			mstatus_mie  <= mstatus_mpie;  // Pop
			mstatus_mpie <= 1'b1;
		end else if (trap_entry) begin
			mstatus_mpie <= mstatus_mie;   // Push, handler runs with IRQs off
			mstatus_mie  <= 1'b0;
		end else if (wsel[WSEL_MSTATUS]) begin
			mstatus_mpie <= mstatus_wr[7];
			mstatus_mie  <= mstatus_wr[3];
		end
	end

	// -------------------------------------------------------------------------
	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch <= '0;
			mie      <= '0;
			mtvec    <= MTVEC_INIT;
		end else begin
			if (wsel[WSEL_MSCRATCH])
				mscratch <= csr_apply(mscratch, wdata, wtype);
			if (wsel[WSEL_MIE])
				mie <= csr_apply(mie, wdata, wtype) & MIE_WMASK;  // Reserved bits read 0
			// Fixed bits of the vector base keep their reset value
			if (wsel[WSEL_MTVEC])
				mtvec <= (csr_apply(mtvec, wdata, wtype) & MTVEC_WMASK)
					| (MTVEC_INIT & ~MTVEC_WMASK);
		end
	end

	// -------------------------------------------------------------------------
	// Registers loaded on trap entry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc   <= '0;
			mcause <= '0;
		end else if (trap_entry) begin
			mepc   <= mepc_in & MEPC_WMASK;
			mcause <= {cause_irq, 26'd0, cause_code};
		end else begin
			if (wsel[WSEL_MEPC])
				mepc <= csr_apply(mepc, wdata, wtype) & MEPC_WMASK;
			if (wsel[WSEL_MCAUSE])
				mcause <= csr_apply(mcause, wdata, wtype) & MCAUSE_WMASK;
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_trap_request.sv
// Trap request logic: IRQ registering, mip, interrupt selection, trap target and cause
`default_nettype none

module csr_trap_request import csr_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire [N_IRQ-1:0]  irq,
	input  wire except_t     except,
	input  wire              delay_irq_entry,
	input  wire              trap_enter_rdy,
	input  wire              mstatus_mie,
	input  wire word_t       mie,
	input  wire word_t       mtvec,
	input  wire word_t       mepc,
	output word_t            mip,
	output word_t            trap_addr,
	output logic             trap_is_irq,
	output logic             trap_enter_vld,
	output logic             trap_take,
	output logic             trap_is_mret,
	output logic             cause_irq,
	output logic [4:0]       cause_code
);

	localparam int W_IRQ_NUM = $clog2(N_IRQ);

	logic [N_IRQ-1:0]     irq_r;
	logic [N_IRQ-1:0]     irq_qual;  // Pending and unmasked per line
	logic [W_IRQ_NUM-1:0] irq_num;
	logic                 irq_any;
	logic                 exc_req;   // Exception or mret, both beat IRQs

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_r <= '0;
		else
			irq_r <= irq;
	end

	// Per-IRQ bits up top, MEIP as the OR of them, no timer or soft IRQ
	assign mip = {irq_r, 4'h0, |irq_r, 3'h0, 1'b0, 3'h0, 1'b0, 3'h0};

	// -------------------------------------------------------------------------
	// Interrupt qualification and selection
	assign irq_qual = irq_r & mie[31:16];
	assign irq_any  = |irq_qual && mie[11] && mstatus_mie && !delay_irq_entry;

	// Lowest index wins
	always_comb begin
		irq_num = '0;
		for (int k = N_IRQ - 1; k >= 0; k--)
			if (irq_qual[k])
				irq_num = W_IRQ_NUM'(k);
	end

	// -------------------------------------------------------------------------
	// Request, target and cause
	assign exc_req      = except != EXCEPT_NONE;
	assign trap_is_mret = except == EXCEPT_MRET;
	assign cause_irq    = !exc_req;
	assign cause_code   = exc_req ? {1'b0, except} : IRQ_CAUSE_BASE + 5'(irq_num);

	assign trap_addr = trap_is_mret ? mepc :
		{mtvec[XLEN-1:2], 2'b00} + {{(XLEN-7){1'b0}}, cause_code, 2'b00};  // Vectored

	assign trap_is_irq    = !exc_req;
	assign trap_enter_vld = exc_req || irq_any;
	assign trap_take      = trap_enter_vld && trap_enter_rdy;

endmodule

`default_nettype wire
